/* src/spitft_pkg.sv */
`default_nettype none

package spitft_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] frame_t;
    typedef logic [3:0]  reg_addr_t;

    // apb register offsets
    localparam reg_addr_t REG_ADDR   = 4'h0;
    localparam reg_addr_t REG_DATA   = 4'h4;
    localparam reg_addr_t REG_STATUS = 4'h8;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        reg_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } cmd_t;

    // pins to the ra8875
    typedef struct packed {
        logic cs_n;
        logic sclk;
        logic mosi;
    } spi_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        GAP   = 2'd2
    } shift_state_t;

endpackage

`default_nettype wire

/* src/spitft_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module spitft_apb_regs (
    input  logic                 clk,
    input  logic                 nrst,
    input  spitft_pkg::apb_req_t apb_req,
    output spitft_pkg::apb_rsp_t apb_rsp,
    output logic                 push,
    output spitft_pkg::cmd_t     push_cmd,
    input  logic                 fifo_full,
    input  logic [3:0]           fifo_count,
    input  logic                 busy
);
    import spitft_pkg::*;

    word_t addr_q;
    word_t status;
    logic  access;
    logic  wr_addr;
    logic  wr_data;
    logic  known;
    logic  bad_access;

    assign access  = apb_req.psel & apb_req.penable; // access phase only
    assign wr_addr = access & apb_req.pwrite & (apb_req.paddr == REG_ADDR);
    assign wr_data = access & apb_req.pwrite & (apb_req.paddr == REG_DATA);

    assign known = (apb_req.paddr == REG_ADDR)
                 | (apb_req.paddr == REG_DATA)
                 | (apb_req.paddr == REG_STATUS);

    // status is read-only
    assign bad_access = access
                      & (~known | (apb_req.pwrite & (apb_req.paddr == REG_STATUS)));

    // a full queue refuses the command here
    assign push     = wr_data & ~fifo_full;
    assign push_cmd = '{addr: addr_q, data: apb_req.pwdata};

    assign status = {24'd0, fifo_count, 2'b00, fifo_full, busy};

    always_comb begin
        apb_rsp.pready  = 1'b1; // no wait states
        apb_rsp.pslverr = bad_access | (wr_data & fifo_full);
        apb_rsp.prdata  = '0;
        if (access && !apb_req.pwrite) begin
            case (apb_req.paddr)
                REG_ADDR:   apb_rsp.prdata = addr_q;
                REG_STATUS: apb_rsp.prdata = status;
                default:    apb_rsp.prdata = '0; // data word and unknown offsets
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            addr_q <= '0;
        end else if (wr_addr) begin
            addr_q <= apb_req.pwdata;
        end
    end

    // every accepted push lands in the queue
    a_push_taken: assert property (
        @(posedge clk) disable iff (!nrst)
        push |=> (fifo_count != 4'd0)
    ) else $error("pushed command missing from the fifo count");

endmodule

`default_nettype wire

/* src/spitft_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module spitft_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             push,
    input  spitft_pkg::cmd_t push_cmd,
    output logic             cmd_valid,
    input  logic             cmd_ready,
    output spitft_pkg::cmd_t pop_cmd,
    output logic             full,
    output logic [3:0]       count
);
    import spitft_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [3:0] DEPTH_CNT = 4'(FIFO_DEPTH); // depth up to 15

    cmd_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             pop;

    // wrap explicitly so depths that are not a power of two work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign cmd_valid = (count != 4'd0);
    assign full      = (count == DEPTH_CNT);
    assign pop       = cmd_valid & cmd_ready;
    assign pop_cmd   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 4'd0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop) begin
                count <= count + 4'd1;
            end else if (pop && !push) begin
                count <= count - 4'd1;
            end
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!nrst)
        count <= DEPTH_CNT
    ) else $error("fifo count above depth");

endmodule

`default_nettype wire

/* src/spitft_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module spitft_shifter #(
    parameter int CLK_DIV = 2
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  spitft_pkg::cmd_t cmd,
    output spitft_pkg::spi_t spi,
    output logic             active
);
    import spitft_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    shift_state_t     state;
    frame_t           frame;
    spi_t             spi_q;
    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       bit_cnt;
    logic             half_done;
    logic             load;
    frame_t           next_frame;

    // address and data bytes interleaved from the top byte pair down
    function automatic frame_t build_frame(input cmd_t c);
        return {c.addr[31:24], c.data[31:24], c.addr[23:16], c.data[23:16],
                c.addr[15:8],  c.data[15:8],  c.addr[7:0],   c.data[7:0]};
    endfunction

    assign cmd_ready  = (state == IDLE);
    assign active     = (state != IDLE);
    assign load       = cmd_valid & cmd_ready;
    assign half_done  = (div_cnt == DIV_LAST);
    assign next_frame = build_frame(cmd);
    assign spi        = spi_q;

    // frame payload
    always_ff @(posedge clk) begin
        if (load) begin
            frame <= next_frame;
        end else if (state == SHIFT && half_done && spi_q.sclk) begin
            frame <= frame << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= IDLE;
            div_cnt <= '0;
            bit_cnt <= 6'd0;
            spi_q   <= '{cs_n: 1'b1, sclk: 1'b0, mosi: 1'b0};
        end else begin
            case (state)
                IDLE: begin
                    if (load) begin
                        state      <= SHIFT;
                        div_cnt    <= '0;
                        bit_cnt    <= 6'd0;
                        spi_q.cs_n <= 1'b0;
                        spi_q.mosi <= next_frame[63]; // first bit ready before sclk rises
                    end
                end
                SHIFT: begin
                    if (!half_done) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        spi_q.sclk <= ~spi_q.sclk;
                        if (spi_q.sclk) begin // falling edge advances a bit
                            if (bit_cnt == 6'd63) begin
                                state      <= GAP;
                                spi_q.cs_n <= 1'b1;
                                spi_q.mosi <= 1'b0;
                            end else begin
                                bit_cnt    <= bit_cnt + 6'd1;
                                spi_q.mosi <= frame[62];
                            end
                        end
                    end
                end
                GAP: begin
                    // cs_n high for CLK_DIV cycles between frames
                    if (half_done) begin
                        div_cnt <= '0;
                        state   <= IDLE;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_cs_low_in_shift: assert property (
        @(posedge clk) disable iff (!nrst)
        (state == SHIFT) |-> !spi_q.cs_n
    ) else $error("cs_n high during shift");

    a_sclk_idle_low: assert property (
        @(posedge clk) disable iff (!nrst)
        spi_q.cs_n |-> !spi_q.sclk
    ) else $error("sclk toggling with cs_n high");

endmodule

`default_nettype wire

/* src/spitft_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spitft_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int CLK_DIV    = 2
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  spitft_pkg::apb_req_t apb_req,
    output spitft_pkg::apb_rsp_t apb_rsp,
    output spitft_pkg::spi_t     spi,
    output logic                 busy
);
    import spitft_pkg::*;

    cmd_t       push_cmd;
    cmd_t       pop_cmd;
    logic       push;
    logic       fifo_full;
    logic [3:0] fifo_count;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       shift_active;

    // queued work or a frame on the pins
    assign busy = cmd_valid | shift_active;

    spitft_apb_regs u_regs (
        .clk        (clk),
        .nrst       (nrst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .push       (push),
        .push_cmd   (push_cmd),
        .fifo_full  (fifo_full),
        .fifo_count (fifo_count),
        .busy       (busy)
    );

    spitft_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .nrst      (nrst),
        .push      (push),
        .push_cmd  (push_cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .pop_cmd   (pop_cmd),
        .full      (fifo_full),
        .count     (fifo_count)
    );

    spitft_shifter #(
        .CLK_DIV (CLK_DIV)
    ) u_shifter (
        .clk       (clk),
        .nrst      (nrst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (pop_cmd),
        .spi       (spi),
        .active    (shift_active)
    );

endmodule

`default_nettype wire

/* testbench/tb_spitft.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spitft;
    import spitft_pkg::*;

    localparam int NUM_PAT = 11;
    localparam int TIMEOUT = 5000; // cycles per wait

    logic        clk;
    logic        nrst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    spi_t        spi;
    logic        busy;
    logic [63:0] pat [3*NUM_PAT];
    frame_t      rx_q [$];
    frame_t      shift_in;
    int          bit_n;
    int          cs_falls;
    int          sent_frames;
    int          errors;
    logic [31:0] lfsr;
    word_t       rdata;
    logic        slverr;
    int          gap;

    spitft_top #(.FIFO_DEPTH(4), .CLK_DIV(2)) uut (
        .clk     (clk),
        .nrst    (nrst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .spi     (spi),
        .busy    (busy)
    );

    always #5 clk = ~clk;

    // display side samples on rising sclk
    always @(posedge spi.sclk) begin
        if (!spi.cs_n) begin
            shift_in = {shift_in[62:0], spi.mosi};
            bit_n++;
            if (bit_n == 64) begin
                rx_q.push_back(shift_in);
                bit_n = 0;
            end
        end
    end

    always @(negedge spi.cs_n) cs_falls++;

    always @(posedge spi.cs_n) begin
        assert (bit_n == 0) else begin
            errors++;
            $display("cs_n went high after only %0d bits of a frame", bit_n);
        end
    end

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_random(input int nbits, output int val);
        val = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr = lfsr_step(lfsr);
            val = (val << 1) | lfsr[0];
        end
    endtask

    task automatic apb_access(input logic write, input reg_addr_t addr, input word_t wdata,
                              output word_t rd, output logic err);
        int n;
        n = 0;
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        require(apb_rsp.pready, $sformatf("apb access to offset %h never completed", addr));
        rd  = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic send_cmd(input int idx, output logic err);
        word_t rd;
        logic  addr_err;
        apb_access(1'b1, REG_ADDR, pat[3*idx][31:0], rd, addr_err);
        require(!addr_err, "address register write was refused");
        apb_access(1'b1, REG_DATA, pat[3*idx+1][31:0], rd, err);
    endtask

    // busy may only fall once no frame is left on the pins
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        require(!busy, {"timed out waiting for the link to go idle in ", what});
        require(spi.cs_n === 1'b1 && bit_n == 0,
                {"busy fell while a frame was still on the pins in ", what});
    endtask

    // frames on the pins against pattern lines first .. first+n-1
    task automatic check_frames(input string name, input int first, input int n);
        frame_t got;
        compare_value({name, "_count"}, n, rx_q.size());
        for (int i = 0; i < n && rx_q.size() > 0; i++) begin
            got = rx_q.pop_front();
            compare_value($sformatf("%s_%0d", name, i), pat[3*(first+i)+2], got);
        end
        rx_q.delete();
        sent_frames += n;
        compare_value({name, "_cs_frames"}, sent_frames, cs_falls);
    endtask

    initial begin
        clk = 1'b0;
        nrst = 1'b0;
        apb_req = '0;
        shift_in = '0;
        bit_n = 0;
        cs_falls = 0;
        sent_frames = 0;
        errors = 0;
        lfsr = 32'hcd74a96e;
        $readmemh("testbench/spitft_patterns.mem", pat);
        repeat (8) @(negedge clk);
        nrst = 1'b1;

        @(negedge clk);
        require(spi.cs_n === 1'b1 && spi.sclk === 1'b0 && spi.mosi === 1'b0,
                "spi pins not idle after reset");
        require(busy === 1'b0, "busy high after reset");
        apb_access(1'b0, REG_STATUS, '0, rdata, slverr);
        compare_value("reset_status", 0, rdata);
        compare_value("reset_pslverr", 0, slverr);

        send_cmd(0, slverr);
        compare_value("single_pslverr", 0, slverr);
        wait_idle("single frame");
        check_frames("single_frame", 0, 1);

        for (int i = 1; i <= 4; i++) begin
            next_random(4, gap);
            repeat (gap) @(negedge clk);
            send_cmd(i, slverr);
            compare_value($sformatf("queued_pslverr_%0d", i), 0, slverr);
        end
        wait_idle("queued frames"); // busy must outlast the last frame
        check_frames("queued_frame", 1, 4);

        // the first goes straight to the shifter and the sixth finds the queue full
        for (int i = 5; i <= 10; i++) begin
            send_cmd(i, slverr);
            compare_value($sformatf("full_pslverr_%0d", i), (i == 10), slverr);
        end
        apb_access(1'b0, REG_STATUS, '0, rdata, slverr);
        compare_value("full_status", 32'h43, rdata);
        wait_idle("full queue");
        check_frames("full_frame", 5, 5);

        apb_access(1'b1, REG_ADDR, 32'h5a3c0f96, rdata, slverr);
        apb_access(1'b0, REG_ADDR, '0, rdata, slverr);
        compare_value("addr_readback", 32'h5a3c0f96, rdata);
        compare_value("addr_read_pslverr", 0, slverr);
        apb_access(1'b0, 4'hc, '0, rdata, slverr);
        compare_value("unknown_read_data", 0, rdata);
        compare_value("unknown_read_pslverr", 1, slverr);
        apb_access(1'b1, REG_STATUS, 32'hffffffff, rdata, slverr);
        compare_value("status_write_pslverr", 1, slverr);
        repeat (4) @(negedge clk);
        check_frames("no_extra_frames", 0, 0);

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/spitft_patterns.mem */
// address word, data word, expected 64-bit frame
// frame bytes are addr3 data3 addr2 data2 addr1 data1 addr0 data0
12345678 9abcdef0 129a34bc56de78f0
00000001 000000ff 00000000000001ff
80000000 00000001 8000000000000001
deadbeef cafef00d decaadfebef0ef0d
ffffffff 00000000 ff00ff00ff00ff00
00000010 0000ff00 0000000000ff1000
a5a5a5a5 5a5a5a5a a55aa55aa55aa55a
01020304 05060708 0105020603070408
00ff00ff 11223344 0011ff220033ff44
76543210 fedcba98 76fe54dc32ba1098
0badc0de 00c0ffee 0b00adc0c0ffdeee

/* src.f */
src/spitft_pkg.sv
src/spitft_apb_regs.sv
src/spitft_cmd_fifo.sv
src/spitft_shifter.sv
src/spitft_top.sv
testbench/tb_spitft.sv
